//--- Makefile
SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := tb_frontend
FLIST   := vlog.f
BUILD   := obj_dir
BIN     := $(BUILD)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/fe_pkg.sv
package fe_pkg;

    // address and instruction word width
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    // instruction queue sizing
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W = 3;
    localparam int QCNT_W = 4;

    // instruction word fields
    localparam int REG_W = 5;
    localparam int OPC_LSB = 26;
    localparam int OPC_W = 6;

    // operation class, zero doubles as the empty-lane value
    typedef enum logic [3:0] {
        OP_ILLEGAL = 4'd0,
        OP_ALU3 = 4'd1,
        OP_ALUI = 4'd2,
        OP_LOAD = 4'd3,
        OP_STORE = 4'd4,
        OP_BRANCH = 4'd5,
        OP_BL = 4'd6,
        OP_CSRXCHG = 4'd7,
        OP_RDCNT = 4'd8,
        OP_INVTLB = 4'd9
    } op_class_e;

    // major opcode of each class
    localparam logic [OPC_W-1:0] OPC_ALU3 = 6'h01;
    localparam logic [OPC_W-1:0] OPC_ALUI = 6'h03;
    localparam logic [OPC_W-1:0] OPC_LOAD = 6'h0a;
    localparam logic [OPC_W-1:0] OPC_STORE = 6'h0b;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 6'h16;
    localparam logic [OPC_W-1:0] OPC_BL = 6'h15;
    localparam logic [OPC_W-1:0] OPC_CSRXCHG = 6'h04;
    localparam logic [OPC_W-1:0] OPC_RDCNT = 6'h00;
    localparam logic [OPC_W-1:0] OPC_INVTLB = 6'h19;
    localparam logic [OPC_W-1:0] OPC_ILLEGAL = 6'h3f;

    // apb fetch sequencer
    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,
        FS_SETUP = 2'd1,
        FS_ACCESS = 2'd2,
        FS_DRAIN = 2'd3
    } fetch_state_e;

endpackage

//--- design/fetch_unit.sv
module fetch_unit import fe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              redirect_i,
    input  logic [XLEN-1:0]   redirect_pc_i,

    input  logic [QCNT_W-1:0] free_cnt_i,

    output logic [XLEN-1:0]   paddr_o,
    output logic              psel_o,
    output logic              penable_o,
    input  logic [XLEN-1:0]   prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i,

    output logic              wr_en_o,
    output logic [XLEN-1:0]   wr_pc_o,
    output logic [XLEN-1:0]   wr_word_o,
    output logic              wr_fault_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic [XLEN-1:0] addr_q;
    logic xfer_done;
    logic keep_done;
    logic start;

    // access phase ends on pready in ACCESS or DRAIN
    assign xfer_done = penable_o && pready_i;

    // only a clean ACCESS completion goes into the queue
    assign keep_done = (state_q == FS_ACCESS) && pready_i && !redirect_i;

    // redirect wins over the next sequential address
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (keep_done) begin
            pc_d = addr_q + XLEN'(4);
        end else begin
            pc_d = pc_q;
        end
    end

    always_comb begin
        state_d = state_q;
        start = 1'b0;
        case (state_q)
            FS_IDLE: begin
                start = (free_cnt_i != '0);
            end
            FS_SETUP: begin
                state_d = redirect_i ? FS_DRAIN : FS_ACCESS;
            end
            FS_ACCESS: begin
                if (xfer_done) begin
                    state_d = FS_IDLE;
                    // a kept word eats one free slot and a redirect empties the queue
                    start = redirect_i || (free_cnt_i > QCNT_W'(1));
                end else if (redirect_i) begin
                    state_d = FS_DRAIN;
                end
            end
            FS_DRAIN: begin
                // stale data so just let the transfer end
                if (xfer_done) begin
                    state_d = FS_IDLE;
                    start = (free_cnt_i != '0);
                end
            end
            default: begin
                state_d = FS_IDLE;
            end
        endcase
        if (start) begin
            state_d = FS_SETUP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= FS_IDLE;
            pc_q <= RESET_PC;
            addr_q <= RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q <= pc_d;
            if (start) begin
                addr_q <= pc_d;
            end
        end
    end

    assign psel_o = (state_q != FS_IDLE);
    assign penable_o = (state_q == FS_ACCESS) || (state_q == FS_DRAIN);
    assign paddr_o = addr_q;

    assign wr_en_o = keep_done;
    assign wr_pc_o = addr_q;
    assign wr_word_o = prdata_i;
    assign wr_fault_o = pslverr_i;

    // address held across the whole transfer even on redirect
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (psel_o && !xfer_done) |=> (psel_o && $stable(paddr_o)));

    // access phase only inside a transfer that was already selected
    a_enable_in_sel: assert property (@(posedge clk) disable iff (!rst_n)
        penable_o |-> (psel_o && $past(psel_o)));

    // queue must still have room when the word arrives
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_o |-> (free_cnt_i != '0));

endmodule

//--- design/frontend.sv
module frontend import fe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    output logic [XLEN-1:0]        paddr_o,
    output logic                   psel_o,
    output logic                   penable_o,
    input  logic [XLEN-1:0]        prdata_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i,

    input  logic                   redirect_i,
    input  logic [XLEN-1:0]        redirect_pc_i,

    input  logic [1:0]             issue_num_i,
    input  logic                   backend_stall_i,

    output logic [1:0]             inst_valid_o,
    output logic [1:0][XLEN-1:0]   inst_pc_o,
    output logic [1:0][XLEN-1:0]   inst_word_o,
    output op_class_e [1:0]        inst_op_o,
    output logic [1:0][REG_W-1:0]  inst_rs0_o,
    output logic [1:0][REG_W-1:0]  inst_rs1_o,
    output logic [1:0][REG_W-1:0]  inst_rd_o,
    output logic [1:0]             inst_fault_o
);

    // fetch to queue
    logic wr_en;
    logic [XLEN-1:0] wr_pc;
    logic [XLEN-1:0] wr_word;
    logic wr_fault;
    logic [QCNT_W-1:0] free_cnt;

    // queue head to decode
    logic [1:0] rd_valid;
    logic [1:0][XLEN-1:0] rd_pc;
    logic [1:0][XLEN-1:0] rd_word;
    logic [1:0] rd_fault;

    fetch_unit i_fetch_unit (
        .clk(clk),
        .rst_n(rst_n),
        .redirect_i(redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .free_cnt_i(free_cnt),
        .paddr_o(paddr_o),
        .psel_o(psel_o),
        .penable_o(penable_o),
        .prdata_i(prdata_i),
        .pready_i(pready_i),
        .pslverr_i(pslverr_i),
        .wr_en_o(wr_en),
        .wr_pc_o(wr_pc),
        .wr_word_o(wr_word),
        .wr_fault_o(wr_fault)
    );

    inst_queue i_inst_queue (
        .clk(clk),
        .rst_n(rst_n),
        .flush_i(redirect_i),
        .wr_en_i(wr_en),
        .wr_pc_i(wr_pc),
        .wr_word_i(wr_word),
        .wr_fault_i(wr_fault),
        .free_cnt_o(free_cnt),
        .pop_num_i(issue_num_i),
        .stall_i(backend_stall_i),
        .rd_valid_o(rd_valid),
        .rd_pc_o(rd_pc),
        .rd_word_o(rd_word),
        .rd_fault_o(rd_fault)
    );

    inst_decode i_inst_decode (
        .rd_valid_i(rd_valid),
        .rd_pc_i(rd_pc),
        .rd_word_i(rd_word),
        .rd_fault_i(rd_fault),
        .inst_valid_o(inst_valid_o),
        .inst_pc_o(inst_pc_o),
        .inst_word_o(inst_word_o),
        .inst_op_o(inst_op_o),
        .inst_rs0_o(inst_rs0_o),
        .inst_rs1_o(inst_rs1_o),
        .inst_rd_o(inst_rd_o),
        .inst_fault_o(inst_fault_o)
    );

endmodule

//--- design/inst_decode.sv
module inst_decode import fe_pkg::*; (
    input  logic [1:0]              rd_valid_i,
    input  logic [1:0][XLEN-1:0]    rd_pc_i,
    input  logic [1:0][XLEN-1:0]    rd_word_i,
    input  logic [1:0]              rd_fault_i,

    output logic [1:0]              inst_valid_o,
    output logic [1:0][XLEN-1:0]    inst_pc_o,
    output logic [1:0][XLEN-1:0]    inst_word_o,
    output op_class_e [1:0]         inst_op_o,
    output logic [1:0][REG_W-1:0]   inst_rs0_o,
    output logic [1:0][REG_W-1:0]   inst_rs1_o,
    output logic [1:0][REG_W-1:0]   inst_rd_o,
    output logic [1:0]              inst_fault_o
);

    op_class_e [1:0] lane_op;
    logic [1:0][REG_W-1:0] lane_rs0;
    logic [1:0][REG_W-1:0] lane_rs1;
    logic [1:0][REG_W-1:0] lane_rd;

    // class from major opcode, then register usage by class
    function automatic void decode_word(
        input  logic [XLEN-1:0]  word,
        input  logic             fault,
        output op_class_e        op,
        output logic [REG_W-1:0] rs0,
        output logic [REG_W-1:0] rs1,
        output logic [REG_W-1:0] rd
    );
        logic [REG_W-1:0] f_rd;
        logic [REG_W-1:0] f_rj;
        logic [REG_W-1:0] f_rk;
        f_rd = word[REG_W-1:0];
        f_rj = word[2*REG_W-1:REG_W];
        f_rk = word[3*REG_W-1:2*REG_W];
        rs0 = '0;
        rs1 = '0;
        rd = '0;
        case (word[OPC_LSB +: OPC_W])
            OPC_ALU3:    op = OP_ALU3;
            OPC_ALUI:    op = OP_ALUI;
            OPC_LOAD:    op = OP_LOAD;
            OPC_STORE:   op = OP_STORE;
            OPC_BRANCH:  op = OP_BRANCH;
            OPC_BL:      op = OP_BL;
            OPC_CSRXCHG: op = OP_CSRXCHG;
            OPC_RDCNT:   op = OP_RDCNT;
            OPC_INVTLB:  op = OP_INVTLB;
            OPC_ILLEGAL: op = OP_ILLEGAL;
            default:     op = OP_ILLEGAL;
        endcase
        // bus error, the word itself is meaningless
        if (fault) begin
            op = OP_ILLEGAL;
        end
        case (op)
            OP_ALU3: begin
                rs0 = f_rk;
                rs1 = f_rj;
                rd = f_rd;
            end
            OP_ALUI, OP_LOAD: begin
                rs1 = f_rj;
                rd = f_rd;
            end
            // rd field is a source here
            OP_STORE, OP_BRANCH: begin
                rs0 = f_rd;
                rs1 = f_rj;
            end
            OP_BL: begin
                rd = REG_W'(1);
            end
            OP_CSRXCHG: begin
                rs0 = f_rd;
                rs1 = f_rj;
                rd = f_rd;
            end
            OP_RDCNT: begin
                rd = f_rd | f_rj;
            end
            OP_INVTLB: begin
                rs0 = f_rk;
                rs1 = f_rj;
            end
            default: begin
                rd = '0;
            end
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            decode_word(rd_word_i[i], rd_fault_i[i], lane_op[i], lane_rs0[i], lane_rs1[i],
                        lane_rd[i]);
            // empty lanes read as all zero
            inst_valid_o[i] = rd_valid_i[i];
            inst_pc_o[i] = rd_valid_i[i] ? rd_pc_i[i] : '0;
            inst_word_o[i] = rd_valid_i[i] ? rd_word_i[i] : '0;
            inst_op_o[i] = rd_valid_i[i] ? lane_op[i] : OP_ILLEGAL;
            inst_rs0_o[i] = rd_valid_i[i] ? lane_rs0[i] : '0;
            inst_rs1_o[i] = rd_valid_i[i] ? lane_rs1[i] : '0;
            inst_rd_o[i] = rd_valid_i[i] ? lane_rd[i] : '0;
            inst_fault_o[i] = rd_valid_i[i] && rd_fault_i[i];
        end
    end

endmodule

//--- design/inst_queue.sv
module inst_queue import fe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush_i,

    input  logic                 wr_en_i,
    input  logic [XLEN-1:0]      wr_pc_i,
    input  logic [XLEN-1:0]      wr_word_i,
    input  logic                 wr_fault_i,

    output logic [QCNT_W-1:0]    free_cnt_o,

    input  logic [1:0]           pop_num_i,
    input  logic                 stall_i,

    output logic [1:0]           rd_valid_o,
    output logic [1:0][XLEN-1:0] rd_pc_o,
    output logic [1:0][XLEN-1:0] rd_word_o,
    output logic [1:0]           rd_fault_o
);

    logic [XLEN-1:0] pc_mem [QUEUE_DEPTH];
    logic [XLEN-1:0] word_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] fault_mem;

    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_p1;
    logic [QCNT_W-1:0] count_q;
    logic [1:0] pop_cnt;
    logic push;

    assign push = wr_en_i;
    assign rd_ptr_p1 = rd_ptr_q + QPTR_W'(1);

    // head and next entry
    assign rd_valid_o[0] = (count_q != '0);
    assign rd_valid_o[1] = (count_q > QCNT_W'(1));

    assign free_cnt_o = QCNT_W'(QUEUE_DEPTH) - count_q;

    // requested pops limited by what is actually there
    always_comb begin
        pop_cnt = 2'd0;
        if (!stall_i) begin
            if ((pop_num_i >= 2'd2) && rd_valid_o[1]) begin
                pop_cnt = 2'd2;
            end else if ((pop_num_i != 2'd0) && rd_valid_o[0]) begin
                pop_cnt = 2'd1;
            end
        end
    end

    always_comb begin
        rd_pc_o[0] = pc_mem[rd_ptr_q];
        rd_word_o[0] = word_mem[rd_ptr_q];
        rd_fault_o[0] = fault_mem[rd_ptr_q];
        rd_pc_o[1] = pc_mem[rd_ptr_p1];
        rd_word_o[1] = word_mem[rd_ptr_p1];
        rd_fault_o[1] = fault_mem[rd_ptr_p1];
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push && !flush_i) begin
            pc_mem[wr_ptr_q] <= wr_pc_i;
            word_mem[wr_ptr_q] <= wr_word_i;
            fault_mem[wr_ptr_q] <= wr_fault_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + QPTR_W'(1);
            end
            rd_ptr_q <= rd_ptr_q + QPTR_W'(pop_cnt);
            count_q <= count_q + QCNT_W'(push) - QCNT_W'(pop_cnt);
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= QCNT_W'(QUEUE_DEPTH));

endmodule

//--- sim/tb_frontend.sv
module tb_frontend import fe_pkg::*; ();

    logic clk;
    logic rst_n;
    logic [XLEN-1:0] paddr_o;
    logic psel_o;
    logic penable_o;
    logic [XLEN-1:0] prdata_i;
    logic pready_i;
    logic pslverr_i;
    logic redirect_i;
    logic [XLEN-1:0] redirect_pc_i;
    logic [1:0] issue_num_i;
    logic backend_stall_i;
    logic [1:0] inst_valid_o;
    logic [1:0][XLEN-1:0] inst_pc_o;
    logic [1:0][XLEN-1:0] inst_word_o;
    op_class_e [1:0] inst_op_o;
    logic [1:0][REG_W-1:0] inst_rs0_o;
    logic [1:0][REG_W-1:0] inst_rs1_o;
    logic [1:0][REG_W-1:0] inst_rd_o;
    logic [1:0] inst_fault_o;

    integer seed;
    int errors;
    int issued;
    int occ;
    int wait_cnt;
    logic [XLEN-1:0] mem [256];
    logic fault_rec [256];
    logic [XLEN-1:0] exp_pc;
    logic cur_fault;
    logic stale;
    logic setup_seen;
    logic prev_busy;
    logic [XLEN-1:0] prev_addr;

    frontend i_frontend (
        .clk(clk),
        .rst_n(rst_n),
        .paddr_o(paddr_o),
        .psel_o(psel_o),
        .penable_o(penable_o),
        .prdata_i(prdata_i),
        .pready_i(pready_i),
        .pslverr_i(pslverr_i),
        .redirect_i(redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .issue_num_i(issue_num_i),
        .backend_stall_i(backend_stall_i),
        .inst_valid_o(inst_valid_o),
        .inst_pc_o(inst_pc_o),
        .inst_word_o(inst_word_o),
        .inst_op_o(inst_op_o),
        .inst_rs0_o(inst_rs0_o),
        .inst_rs1_o(inst_rs1_o),
        .inst_rd_o(inst_rd_o),
        .inst_fault_o(inst_fault_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_op(input op_class_e got, input op_class_e exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
            errors++;
        end
    endtask

    task automatic check_reg(input logic [REG_W-1:0] got, input logic [REG_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // random words, opcodes taken from the class table
    task automatic fill_memory();
        logic [OPC_W-1:0] opc_table [10];
        logic [3:0] pick;
        opc_table[0] = OPC_ALU3;
        opc_table[1] = OPC_ALUI;
        opc_table[2] = OPC_LOAD;
        opc_table[3] = OPC_STORE;
        opc_table[4] = OPC_BRANCH;
        opc_table[5] = OPC_BL;
        opc_table[6] = OPC_CSRXCHG;
        opc_table[7] = OPC_RDCNT;
        opc_table[8] = OPC_INVTLB;
        opc_table[9] = OPC_ILLEGAL;
        for (int a = 0; a < 256; a++) begin
            pick = 4'({$random(seed)} % 10);
            mem[8'(a)] = {opc_table[pick], 26'($random(seed))};
            fault_rec[8'(a)] = 1'b0;
        end
    endtask

    // class table: which fields each class reads and writes
    function automatic void expect_decode(input logic [XLEN-1:0] w, input logic flt,
                                          output op_class_e op,
                                          output logic [REG_W-1:0] s0,
                                          output logic [REG_W-1:0] s1,
                                          output logic [REG_W-1:0] d);
        logic [OPC_W-1:0] opc;
        opc = w[31:26];
        if (flt) op = OP_ILLEGAL;
        else if (opc == OPC_ALU3) op = OP_ALU3;
        else if (opc == OPC_ALUI) op = OP_ALUI;
        else if (opc == OPC_LOAD) op = OP_LOAD;
        else if (opc == OPC_STORE) op = OP_STORE;
        else if (opc == OPC_BRANCH) op = OP_BRANCH;
        else if (opc == OPC_BL) op = OP_BL;
        else if (opc == OPC_CSRXCHG) op = OP_CSRXCHG;
        else if (opc == OPC_RDCNT) op = OP_RDCNT;
        else if (opc == OPC_INVTLB) op = OP_INVTLB;
        else op = OP_ILLEGAL;
        s0 = '0;
        s1 = '0;
        d = '0;
        if (op inside {OP_ALU3, OP_INVTLB}) s0 = w[14:10];
        if (op inside {OP_STORE, OP_BRANCH, OP_CSRXCHG}) s0 = w[4:0];
        if (op inside {OP_ALU3, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH, OP_CSRXCHG,
                       OP_INVTLB}) s1 = w[9:5];
        if (op inside {OP_ALU3, OP_ALUI, OP_LOAD, OP_CSRXCHG}) d = w[4:0];
        if (op == OP_BL) d = 5'd1;
        if (op == OP_RDCNT) d = w[4:0] | w[9:5];
    endfunction

    // one issued lane against the next expected pc
    task automatic check_lane(input logic lane);
        logic [XLEN-1:0] word;
        logic flt;
        op_class_e e_op;
        logic [REG_W-1:0] e_rs0;
        logic [REG_W-1:0] e_rs1;
        logic [REG_W-1:0] e_rd;
        string tag;
        word = mem[exp_pc[9:2]];
        flt = fault_rec[exp_pc[9:2]];
        tag = $sformatf("lane %0d", lane);
        expect_decode(word, flt, e_op, e_rs0, e_rs1, e_rd);
        check_pc(inst_pc_o[lane], exp_pc, {tag, " pc"});
        check_word(inst_word_o[lane], word, {tag, " word"});
        check_flag(inst_fault_o[lane], flt, {tag, " fault"});
        check_op(inst_op_o[lane], e_op, {tag, " op"});
        check_reg(inst_rs0_o[lane], e_rs0, {tag, " rs0"});
        check_reg(inst_rs1_o[lane], e_rs1, {tag, " rs1"});
        check_reg(inst_rd_o[lane], e_rd, {tag, " rd"});
        exp_pc = exp_pc + 32'd4;
        issued++;
    endtask

    task automatic check_protocol();
        if (penable_o && !psel_o) begin
            $display("Protocol error at %0t: penable_o high without psel_o", $time);
            errors++;
        end
        if (prev_busy && (!psel_o || paddr_o !== prev_addr)) begin
            $display("Protocol error at %0t: transfer changed before completion", $time);
            errors++;
        end
        if (occ >= QUEUE_DEPTH && psel_o) begin
            $display("Protocol error at %0t: fetch started with the queue full", $time);
            errors++;
        end
        if (inst_valid_o[1] && !inst_valid_o[0]) begin
            $display("Protocol error at %0t: lane 1 valid without lane 0", $time);
            errors++;
        end
        check_flag(inst_valid_o[0], occ > 0, "lane 0 valid");
        check_flag(inst_valid_o[1], occ > 1, "lane 1 valid");
    endtask

    // apb memory with random wait states and bus errors
    task automatic respond_apb();
        if (psel_o && !penable_o) begin
            setup_seen = 1'b1;
            stale = 1'b0;
            wait_cnt = {$random(seed)} % 4;
            cur_fault = ({$random(seed)} % 16) == 0;
            pready_i = 1'b0;
            pslverr_i = 1'b0;
        end else if (penable_o && wait_cnt == 0) begin
            pready_i = 1'b1;
            prdata_i = mem[paddr_o[9:2]];
            pslverr_i = cur_fault;
            fault_rec[paddr_o[9:2]] = cur_fault;
        end else begin
            if (penable_o) wait_cnt--;
            pready_i = 1'b0;
            pslverr_i = 1'b0;
        end
    endtask

    // sample at the falling edge, then drive the next cycle's inputs
    task automatic run_cycle(input logic redir_en, input logic hold);
        logic done_now;
        int n_pop;
        int n_valid;
        @(negedge clk);
        check_protocol();
        respond_apb();
        done_now = penable_o && pready_i;
        prev_busy = psel_o && !done_now;
        prev_addr = paddr_o;
        redirect_i = redir_en && (({$random(seed)} % 60) == 0);
        backend_stall_i = hold || (({$random(seed)} % 5) == 0);
        issue_num_i = 2'({$random(seed)} % 3);
        n_valid = int'(inst_valid_o[0]) + int'(inst_valid_o[1]);
        if (redirect_i) begin
            redirect_pc_i = RESET_PC + ({$random(seed)} & 32'h0000_03fc);
            // transfer in flight is now stale
            if (psel_o) stale = 1'b1;
            exp_pc = redirect_pc_i;
            occ = 0;
        end else begin
            n_pop = backend_stall_i ? 0 : int'(issue_num_i);
            if (n_pop > n_valid) n_pop = n_valid;
            if (n_pop > 0) check_lane(1'b0);
            if (n_pop > 1) check_lane(1'b1);
            occ = occ - n_pop + ((done_now && !stale) ? 1 : 0);
        end
    endtask

    task automatic report_test(input string name, input int err0, input int iss0);
        if (issued == iss0) begin
            $display("test %s: no instruction was issued", name);
            errors++;
        end
        $display("test %s: %0d issued, %0d errors", name, issued - iss0, errors - err0);
    endtask

    initial begin
        int n;
        int t_err;
        int t_iss;
        seed = 80160;
        errors = 0;
        issued = 0;
        occ = 0;
        wait_cnt = 0;
        exp_pc = RESET_PC;
        cur_fault = 1'b0;
        stale = 1'b0;
        setup_seen = 1'b0;
        prev_busy = 1'b0;
        prev_addr = '0;
        rst_n = 1'b0;
        prdata_i = '0;
        pready_i = 1'b0;
        pslverr_i = 1'b0;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        issue_num_i = 2'd0;
        backend_stall_i = 1'b0;
        fill_memory();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        t_err = errors;
        t_iss = issued;
        repeat (400) run_cycle(1'b0, 1'b0);
        report_test("sequential fetch and decode", t_err, t_iss);

        // long stall fills the queue, then release
        t_err = errors;
        t_iss = issued;
        n = 0;
        while (occ < QUEUE_DEPTH && n < 200) begin
            run_cycle(1'b0, 1'b1);
            n++;
        end
        if (occ < QUEUE_DEPTH) begin
            $display("Timeout at %0t: queue did not fill while stalled", $time);
            errors++;
        end
        repeat (30) run_cycle(1'b0, 1'b1);
        setup_seen = 1'b0;
        n = 0;
        while (!setup_seen && n < 100) begin
            run_cycle(1'b0, 1'b0);
            n++;
        end
        if (!setup_seen) begin
            $display("Timeout at %0t: fetch did not resume after the stall", $time);
            errors++;
        end
        repeat (60) run_cycle(1'b0, 1'b0);
        report_test("back-pressure", t_err, t_iss);

        t_err = errors;
        t_iss = issued;
        repeat (1200) run_cycle(1'b1, 1'b0);
        report_test("redirect", t_err, t_iss);

        $display("total: %0d instructions issued, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/fe_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/inst_decode.sv
design/frontend.sv
sim/tb_frontend.sv
